/* hw/rv_pkg.sv */
package rv_pkg;

	localparam int XLEN = 32;
	localparam logic [XLEN-1:0] PC_RESET = '0;

	// branch funct3 codes
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [4:0] reg_idx_t;

	typedef struct packed {
		logic [6:0] funct7;	// bit 30 is funct7[5]
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} instr_t;

	typedef enum logic [6:0] {
		OP       = 7'b0110011,
		OP_IMM   = 7'b0010011,
		LUI      = 7'b0110111,
		AUIPC    = 7'b0010111,
		JAL      = 7'b1101111,
		JALR     = 7'b1100111,
		BRANCH   = 7'b1100011,
		LOAD     = 7'b0000011,
		STORE    = 7'b0100011,
		MISC_MEM = 7'b0001111,
		SYSTEM   = 7'b1110011
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_B,	// lui
		ALU_LINK	// a + 4, return address
	} alu_op_t;

	typedef enum logic [2:0] {
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J,
		IMM_NONE
	} imm_fmt_t;

endpackage

/* hw/exec_ctrl_if.sv */
`timescale 1ns/1ps

interface exec_ctrl_if;

	rv_pkg::alu_op_t  alu_op;
	logic             a_sel_pc;		// operand a from pc
	logic             b_sel_imm;	// operand b from immediate
	rv_pkg::imm_fmt_t imm_fmt;
	logic             rd_wr;
	logic             is_branch;
	logic             is_jal;
	logic             is_jalr;

	modport ctrl (
		output alu_op, a_sel_pc, b_sel_imm, imm_fmt,
		output rd_wr, is_branch, is_jal, is_jalr
	);

	modport dp (
		input alu_op, a_sel_pc, b_sel_imm, imm_fmt,
		input rd_wr, is_branch, is_jal, is_jalr
	);

endinterface

/* hw/exec_ctrl.sv */
`timescale 1ns/1ps

module exec_ctrl (
	input rv_pkg::instr_t instr,
	exec_ctrl_if.ctrl     ctl
);

	rv_pkg::opcode_t opcode;
	logic            bit30;

	// funct3 to alu op, alt picks sub/sra
	function automatic rv_pkg::alu_op_t f3_to_alu(
		input logic [2:0] f3,
		input logic       alt,
		input logic       sub_ok
	);
		rv_pkg::alu_op_t op;
		unique case (f3)
			3'b000: op = (alt && sub_ok) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001: op = rv_pkg::ALU_SLL;
			3'b010: op = rv_pkg::ALU_SLT;
			3'b011: op = rv_pkg::ALU_SLTU;
			3'b100: op = rv_pkg::ALU_XOR;
			3'b101: op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110: op = rv_pkg::ALU_OR;
			default: op = rv_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = rv_pkg::opcode_t'(instr.opcode);
	assign bit30  = instr.funct7[5];

	always_comb begin
		ctl.alu_op    = rv_pkg::ALU_ADD;
		ctl.a_sel_pc  = 1'b0;
		ctl.b_sel_imm = 1'b0;
		ctl.imm_fmt   = rv_pkg::IMM_NONE;
		ctl.rd_wr     = 1'b0;
		ctl.is_branch = 1'b0;
		ctl.is_jal    = 1'b0;
		ctl.is_jalr   = 1'b0;
		unique case (opcode)
			rv_pkg::OP: begin
				ctl.alu_op = f3_to_alu(instr.funct3, bit30, 1'b1);
				ctl.rd_wr  = 1'b1;
			end
			rv_pkg::OP_IMM: begin
				ctl.alu_op    = f3_to_alu(instr.funct3, bit30, 1'b0);	// no subi
				ctl.b_sel_imm = 1'b1;
				ctl.imm_fmt   = rv_pkg::IMM_I;
				ctl.rd_wr     = 1'b1;
			end
			rv_pkg::LUI: begin
				ctl.alu_op    = rv_pkg::ALU_PASS_B;
				ctl.b_sel_imm = 1'b1;
				ctl.imm_fmt   = rv_pkg::IMM_U;
				ctl.rd_wr     = 1'b1;
			end
			rv_pkg::AUIPC: begin
				ctl.a_sel_pc  = 1'b1;
				ctl.b_sel_imm = 1'b1;
				ctl.imm_fmt   = rv_pkg::IMM_U;
				ctl.rd_wr     = 1'b1;
			end
			rv_pkg::JAL: begin
				ctl.alu_op   = rv_pkg::ALU_LINK;
				ctl.a_sel_pc = 1'b1;
				ctl.imm_fmt  = rv_pkg::IMM_J;	// target offset for pc_unit
				ctl.rd_wr    = 1'b1;
				ctl.is_jal   = 1'b1;
			end
			rv_pkg::JALR: begin
				ctl.alu_op   = rv_pkg::ALU_LINK;
				ctl.a_sel_pc = 1'b1;
				ctl.imm_fmt  = rv_pkg::IMM_I;
				ctl.rd_wr    = 1'b1;
				ctl.is_jalr  = 1'b1;
			end
			rv_pkg::BRANCH: begin
				ctl.imm_fmt   = rv_pkg::IMM_B;
				ctl.is_branch = 1'b1;
			end
			rv_pkg::LOAD:  ctl.imm_fmt = rv_pkg::IMM_I;	// decoded, not executed
			rv_pkg::STORE: ctl.imm_fmt = rv_pkg::IMM_S;
			default: ;	// misc_mem, system, unknown just advance pc
		endcase
	end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input  logic             clk,
	input  logic             rst,
	input  logic             issue,
	exec_ctrl_if.dp          ctl,
	input  rv_pkg::reg_idx_t rs1,
	input  rv_pkg::reg_idx_t rs2,
	input  rv_pkg::reg_idx_t rd,
	input  rv_pkg::data_t    wd,
	output rv_pkg::data_t    rs1_val,
	output rv_pkg::data_t    rs2_val,
	output logic             wb_valid,
	output rv_pkg::reg_idx_t wb_rd,
	output rv_pkg::data_t    wb_data
);

	rv_pkg::data_t regs [32];

	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];	// x0 reads zero
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (issue && ctl.rd_wr && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	// retire report, one cycle after issue
	always_ff @(posedge clk) begin
		if (rst)
			wb_valid <= 1'b0;
		else
			wb_valid <= issue && ctl.rd_wr;	// reported even for x0
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			wb_rd   <= rd;
			wb_data <= wd;
		end
	end

endmodule

/* hw/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
	input  rv_pkg::instr_t instr,
	exec_ctrl_if.dp        ctl,
	output rv_pkg::data_t  imm
);

	logic [31:0] ib;

	assign ib = instr;

	always_comb begin
		unique case (ctl.imm_fmt)
			rv_pkg::IMM_I: imm = {{20{ib[31]}}, ib[31:20]};
			rv_pkg::IMM_S: imm = {{20{ib[31]}}, ib[31:25], ib[11:7]};
			rv_pkg::IMM_B: imm = {{19{ib[31]}}, ib[31], ib[7], ib[30:25], ib[11:8], 1'b0};
			rv_pkg::IMM_U: imm = {ib[31:12], 12'b0};
			rv_pkg::IMM_J: imm = {{11{ib[31]}}, ib[31], ib[19:12], ib[20], ib[30:21], 1'b0};
			default:       imm = '0;	// imm_none
		endcase
	end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
	exec_ctrl_if.dp       ctl,
	input  rv_pkg::data_t rs1_val,
	input  rv_pkg::data_t rs2_val,
	input  rv_pkg::data_t pc,
	input  rv_pkg::data_t imm,
	output rv_pkg::data_t result
);

	rv_pkg::data_t a;
	rv_pkg::data_t b;
	rv_pkg::data_t sum;
	rv_pkg::data_t diff;
	logic [4:0]    shamt;
	logic          lt_s;
	logic          lt_u;

	assign a     = ctl.a_sel_pc ? pc : rs1_val;
	assign b     = ctl.b_sel_imm ? imm : rs2_val;
	assign sum   = a + b;
	assign diff  = a - b;
	assign shamt = b[4:0];	// immediate shifts land here too
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		unique case (ctl.alu_op)
			rv_pkg::ALU_ADD:    result = sum;
			rv_pkg::ALU_SUB:    result = diff;
			rv_pkg::ALU_AND:    result = a & b;
			rv_pkg::ALU_OR:     result = a | b;
			rv_pkg::ALU_XOR:    result = a ^ b;
			rv_pkg::ALU_SLT:    result = {31'b0, lt_s};
			rv_pkg::ALU_SLTU:   result = {31'b0, lt_u};
			rv_pkg::ALU_SLL:    result = a << shamt;
			rv_pkg::ALU_SRL:    result = a >> shamt;
			rv_pkg::ALU_SRA:    result = rv_pkg::data_t'($signed(a) >>> shamt);
			rv_pkg::ALU_PASS_B: result = b;
			rv_pkg::ALU_LINK:   result = a + 32'd4;	// return address
			default:            result = sum;
		endcase
	end

endmodule

/* hw/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
	input  logic          clk,
	input  logic          rst,
	input  logic          issue,
	exec_ctrl_if.dp       ctl,
	input  logic [2:0]    funct3,
	input  rv_pkg::data_t rs1_val,
	input  rv_pkg::data_t rs2_val,
	input  rv_pkg::data_t imm,
	output rv_pkg::data_t pc
);

	logic          taken;
	rv_pkg::data_t jalr_tgt;
	rv_pkg::data_t pc_next;

	// branch comparator
	always_comb begin
		unique case (funct3)
			rv_pkg::F3_BEQ:  taken = rs1_val == rs2_val;
			rv_pkg::F3_BNE:  taken = rs1_val != rs2_val;
			rv_pkg::F3_BLT:  taken = $signed(rs1_val) < $signed(rs2_val);
			rv_pkg::F3_BGE:  taken = $signed(rs1_val) >= $signed(rs2_val);
			rv_pkg::F3_BLTU: taken = rs1_val < rs2_val;
			rv_pkg::F3_BGEU: taken = rs1_val >= rs2_val;
			default:         taken = 1'b0;	// reserved encodings fall through
		endcase
	end

	assign jalr_tgt = (rs1_val + imm) & ~32'd1;

	always_comb begin
		if ((ctl.is_branch && taken) || ctl.is_jal)
			pc_next = pc + imm;
		else if (ctl.is_jalr)
			pc_next = jalr_tgt;
		else
			pc_next = pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= rv_pkg::PC_RESET;
		else if (issue)
			pc <= pc_next;
	end

endmodule

/* hw/exec_core.sv */
`timescale 1ns/1ps

module exec_core (
	input  logic             clk,
	input  logic             rst,
	input  logic             issue,
	input  rv_pkg::instr_t   instr,
	output rv_pkg::data_t    pc,
	output logic             wb_valid,
	output rv_pkg::reg_idx_t wb_rd,
	output rv_pkg::data_t    wb_data
);

	rv_pkg::data_t rs1_val;
	rv_pkg::data_t rs2_val;
	rv_pkg::data_t imm;
	rv_pkg::data_t alu_result;

	exec_ctrl_if ctl_if ();

	exec_ctrl ctrl0 (
		.instr (instr),
		.ctl   (ctl_if.ctrl)
	);

	imm_gen imm0 (
		.instr (instr),
		.ctl   (ctl_if.dp),
		.imm   (imm)
	);

	alu alu0 (
		.ctl     (ctl_if.dp),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.pc      (pc),
		.imm     (imm),
		.result  (alu_result)
	);

	pc_unit pc0 (
		.clk     (clk),
		.rst     (rst),
		.issue   (issue),
		.ctl     (ctl_if.dp),
		.funct3  (instr.funct3),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.imm     (imm),
		.pc      (pc)
	);

	reg_file rf0 (
		.clk      (clk),
		.rst      (rst),
		.issue    (issue),
		.ctl      (ctl_if.dp),
		.rs1      (instr.rs1),
		.rs2      (instr.rs2),
		.rd       (instr.rd),
		.wd       (alu_result),	// every write comes from the alu
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

endmodule

/* dv/exec_core_checker.sv */
`timescale 1ns/1ps

module exec_core_checker (
	input logic          clk,
	input logic          rst,
	input logic          issue,
	input rv_pkg::data_t pc,
	input logic          wb_valid
);

	// a retire report needs an issue one cycle earlier
	wb_after_issue: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> $past(issue))
		else $error("wb_valid high without an issue in the previous cycle");

	wb_low_after_reset: assert property (@(posedge clk)
		$past(rst) |-> !wb_valid)
		else $error("wb_valid high right after reset");

	pc_aligned: assert property (@(posedge clk) disable iff (rst)
		pc[0] == 1'b0)
		else $error("pc bit 0 is set");

	pc_hold_when_idle: assert property (@(posedge clk) disable iff (rst)
		(!$past(issue) && !$past(rst)) |-> pc == $past(pc))
		else $error("pc moved during an idle cycle");

endmodule

bind exec_core exec_core_checker chk0 (
	.clk      (clk),
	.rst      (rst),
	.issue    (issue),
	.pc       (pc),
	.wb_valid (wb_valid)
);

/* dv/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;

	localparam int          NUM_ISSUE    = 2000;
	localparam int          MAX_CYCLES   = 4000;
	localparam int          RESET_CYCLES = 8;
	localparam logic [31:0] SEED         = 32'he1ae;

	logic             clk;
	logic             rst;
	logic             issue;
	rv_pkg::instr_t   instr;
	rv_pkg::data_t    pc;
	logic             wb_valid;
	rv_pkg::reg_idx_t wb_rd;
	rv_pkg::data_t    wb_data;

	// reference model state
	logic [31:0] mregs [32];
	logic [31:0] mpc;
	logic        exp_valid;
	logic [4:0]  exp_rd;
	logic [31:0] exp_data;
	logic [4:0]  last_rd;
	logic [31:0] rng;

	exec_core dut0 (
		.clk      (clk),
		.rst      (rst),
		.issue    (issue),
		.instr    (instr),
		.pc       (pc),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

	always #10 clk = ~clk;	// 20 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic rv_pkg::instr_t make_instr();
		rv_pkg::instr_t ins;
		logic [31:0]    r;
		logic [3:0]     kind;
		r    = rand32();
		ins  = rand32();	// random fields everywhere
		kind = r[3:0];
		if (r[4])
			ins.rs1 = last_rd;	// chain on the previous result
		if (kind <= 4'd4) begin
			ins.opcode = rv_pkg::OP;
			ins.funct7 = (r[5] && (ins.funct3 == 3'b000 || ins.funct3 == 3'b101)) ? 7'h20 : 7'h00;
		end else if (kind <= 4'd8) begin
			ins.opcode = rv_pkg::OP_IMM;
			if (ins.funct3 == 3'b001)
				ins.funct7 = 7'h00;	// slli
			else if (ins.funct3 == 3'b101)
				ins.funct7 = r[5] ? 7'h20 : 7'h00;	// srli / srai
		end else if (kind == 4'd9) begin
			ins.opcode = rv_pkg::LUI;
		end else if (kind == 4'd10) begin
			ins.opcode = rv_pkg::AUIPC;
		end else if (kind <= 4'd12) begin
			ins.opcode = rv_pkg::BRANCH;
			if (!ins.funct3[2])
				ins.funct3[1] = 1'b0;	// skip reserved 010 and 011
		end else if (kind == 4'd13) begin
			ins.opcode = rv_pkg::JAL;
		end else if (kind == 4'd14) begin
			ins.opcode = rv_pkg::JALR;
			ins.funct3 = 3'b000;
		end else begin
			case (r[7:5])
				3'd0:    ins.opcode = rv_pkg::LOAD;
				3'd1:    ins.opcode = rv_pkg::STORE;
				3'd2:    ins.opcode = rv_pkg::MISC_MEM;
				3'd3:    ins.opcode = rv_pkg::SYSTEM;
				3'd4:    ins.opcode = 7'h0b;	// custom opcodes the core does not know
				3'd5:    ins.opcode = 7'h2b;
				3'd6:    ins.opcode = 7'h5b;
				default: ins.opcode = 7'h7b;
			endcase
		end
		return ins;
	endfunction

	// RV32I integer op where alt selects sub or sra
	function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
		input logic [31:0] x, input logic [31:0] y);
		case (f3)
			3'b000:  return alt ? x - y : x + y;
			3'b001:  return x << y[4:0];
			3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			3'b011:  return (x < y) ? 32'd1 : 32'd0;
			3'b100:  return x ^ y;
			3'b101:  return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'b110:  return x | y;
			default: return x & y;
		endcase
	endfunction

	task automatic run_model(input rv_pkg::instr_t ins);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] ii;
		logic [31:0] iu;
		logic [31:0] ib;
		logic [31:0] ij;
		logic [31:0] npc;
		logic        take;
		a    = mregs[ins.rs1];
		b    = mregs[ins.rs2];
		ii   = {{20{ins.funct7[6]}}, ins.funct7, ins.rs2};
		iu   = {ins.funct7, ins.rs2, ins.rs1, ins.funct3, 12'h000};
		ib   = {{20{ins.funct7[6]}}, ins.rd[0], ins.funct7[5:0], ins.rd[4:1], 1'b0};
		ij   = {{12{ins.funct7[6]}}, ins.rs1, ins.funct3, ins.rs2[0], ins.funct7[5:0],
			ins.rs2[4:1], 1'b0};
		npc  = mpc + 32'd4;
		take = 1'b0;
		exp_valid = 1'b0;
		exp_data  = 32'd0;
		case (ins.opcode)
			rv_pkg::OP: begin
				exp_valid = 1'b1;
				exp_data  = arith(ins.funct3, ins.funct7[5], a, b);
			end
			rv_pkg::OP_IMM: begin
				exp_valid = 1'b1;
				exp_data  = arith(ins.funct3, ins.funct7[5] && ins.funct3 == 3'b101, a, ii);
			end
			rv_pkg::LUI: begin
				exp_valid = 1'b1;
				exp_data  = iu;
			end
			rv_pkg::AUIPC: begin
				exp_valid = 1'b1;
				exp_data  = mpc + iu;
			end
			rv_pkg::JAL: begin
				exp_valid = 1'b1;
				exp_data  = mpc + 32'd4;
				npc       = mpc + ij;
			end
			rv_pkg::JALR: begin
				exp_valid = 1'b1;
				exp_data  = mpc + 32'd4;
				npc       = (a + ii) & 32'hffff_fffe;
			end
			rv_pkg::BRANCH: begin
				case (ins.funct3)
					3'b000:  take = a == b;
					3'b001:  take = a != b;
					3'b100:  take = $signed(a) < $signed(b);
					3'b101:  take = $signed(a) >= $signed(b);
					3'b110:  take = a < b;
					3'b111:  take = a >= b;
					default: take = 1'b0;
				endcase
				if (take)
					npc = mpc + ib;
			end
			default: ;	// no write and pc + 4
		endcase
		if (exp_valid && ins.rd != 5'd0)
			mregs[ins.rd] = exp_data;
		exp_rd = ins.rd;
		mpc    = npc;
	endtask

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_outputs();
		compare_value("pc", pc, mpc);
		if (issue) begin
			compare_value("wb_valid", {31'b0, wb_valid}, {31'b0, exp_valid});
			if (exp_valid) begin
				compare_value("wb_rd", {27'b0, wb_rd}, {27'b0, exp_rd});
				compare_value("wb_data", wb_data, exp_data);
			end
		end else begin
			compare_value("wb_valid when idle", {31'b0, wb_valid}, 32'd0);
		end
	endtask

	initial begin
		int             wait_cnt;
		int             cycles;
		int             n_issued;
		logic [31:0]    r;
		rv_pkg::instr_t ins;
		clk      = 1'b0;
		rst      = 1'b1;
		issue    = 1'b0;
		instr    = '0;
		rng      = SEED;
		mpc      = rv_pkg::PC_RESET;
		last_rd  = 5'd0;
		cycles   = 0;
		n_issued = 0;
		for (int i = 0; i < 32; i++)
			mregs[i] = 32'd0;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		wait_cnt = 0;
		while ((pc !== rv_pkg::PC_RESET || wb_valid !== 1'b0) && wait_cnt < 16) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (pc !== rv_pkg::PC_RESET || wb_valid !== 1'b0) begin
			$display("reset did not clear pc and wb_valid within 16 cycles");
			$display("CHECKS FAILED");
			$fatal(1, "reset timeout");
		end

		while (n_issued < NUM_ISSUE && cycles < MAX_CYCLES) begin
			r     = rand32();
			ins   = make_instr();
			issue = (r[1:0] != 2'b00);	// idle about one cycle in four
			instr = ins;
			if (issue) begin
				run_model(ins);
				last_rd = ins.rd;
				n_issued++;
			end
			@(posedge clk);
			@(negedge clk);
			check_outputs();
			cycles++;
		end

		if (n_issued < NUM_ISSUE) begin
			$display("stimulus loop ran out of cycles after %0d issues", n_issued);
			$display("CHECKS FAILED");
			$fatal(1, "cycle limit reached");
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

/* exec_core.f */
hw/rv_pkg.sv
hw/exec_ctrl_if.sv
hw/exec_ctrl.sv
hw/reg_file.sv
hw/imm_gen.sv
hw/alu.sv
hw/pc_unit.sv
hw/exec_core.sv
dv/exec_core_checker.sv
dv/exec_core_tb.sv

/* run.sh */
#!/bin/sh
# build the exec_core testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module exec_core_tb \
	-f exec_core.f -o exec_core_sim > build.log 2>&1 &&
./obj_dir/exec_core_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; } || true
grep -q "ALL CHECKS PASSED" sim.log || { echo "build or run did not complete"; exit 1; }
echo "simulation passed"
exit 0
